//--- source/mips_pkg.sv
package mips_pkg;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 16;
    localparam int NUM_REGS   = 32;

    typedef logic [31:0]                     word_t;
    typedef logic [4:0]                      reg_idx_t;
    typedef logic [$clog2(IMEM_DEPTH)-1:0]   imem_addr_t;
    typedef logic [$clog2(DMEM_DEPTH)-1:0]   dmem_addr_t;
    typedef logic [2:0]                      alu_op_t;
    typedef logic [1:0]                      fwd_sel_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    // Operand source in EX
    localparam fwd_sel_t FWD_NONE  = 2'd0;
    localparam fwd_sel_t FWD_EXMEM = 2'd1;
    localparam fwd_sel_t FWD_MEMWB = 2'd2;

    // Opcodes, bits 31:26
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_HALT  = 6'h3F;

    // R-type funct, bits 5:0
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2A;

endpackage

//--- source/pipe_links.sv
interface id_ex_link;
    mips_pkg::word_t    rs_data;
    mips_pkg::word_t    rt_data;
    mips_pkg::reg_idx_t rs;
    mips_pkg::reg_idx_t rt;
    mips_pkg::reg_idx_t dest;
    mips_pkg::word_t    imm;
    mips_pkg::word_t    pc;
    mips_pkg::alu_op_t  alu_op;
    logic               alu_src_imm;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               branch_eq;
    logic               branch_ne;
    logic               halt;

    modport producer (output rs_data, rt_data, rs, rt, dest, imm, pc, alu_op, alu_src_imm,
                      reg_write, mem_read, mem_write, branch_eq, branch_ne, halt);
    modport consumer (input rs_data, rt_data, dest, imm, pc, alu_op, alu_src_imm,
                      reg_write, mem_read, mem_write, branch_eq, branch_ne, halt);
    modport watch (input rs, rt, dest, mem_read);
endinterface

interface ex_mem_link;
    mips_pkg::word_t    alu_result;
    mips_pkg::word_t    store_data;
    mips_pkg::reg_idx_t dest;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               halt;

    modport producer (output alu_result, store_data, dest, reg_write, mem_read, mem_write, halt);
    modport consumer (input alu_result, store_data, dest, reg_write, mem_read, mem_write, halt);
    modport watch (input dest, reg_write);
endinterface

interface mem_wb_link;
    mips_pkg::word_t    wb_data;
    mips_pkg::reg_idx_t dest;
    logic               reg_write;
    logic               halt;

    modport producer (output wb_data, dest, reg_write, halt);
    modport consumer (input wb_data, dest, reg_write);
    modport watch (input wb_data, dest, reg_write);
endinterface

//--- source/stage_fetch.sv
module stage_fetch (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_imem_we,
    input  mips_pkg::imem_addr_t   i_imem_addr,
    input  mips_pkg::word_t        i_imem_data,
    input  logic                   i_stall,
    input  logic                   i_flush,
    input  logic                   i_branch_taken,
    input  mips_pkg::word_t        i_branch_target,
    input  logic                   i_halt_seen,
    output mips_pkg::word_t        o_pc,
    output mips_pkg::word_t        o_ifid_instr,
    output mips_pkg::word_t        o_ifid_pc
);

    mips_pkg::word_t imem [mips_pkg::IMEM_DEPTH];
    mips_pkg::word_t pc_q;
    mips_pkg::word_t fetch_instr;

    // Program load port, usable while the core is in reset
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    assign fetch_instr = imem[mips_pkg::imem_addr_t'(pc_q)];
    assign o_pc        = pc_q;

    // PC counts words
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= '0;
        end else if (i_branch_taken) begin
            pc_q <= i_branch_target;
        end else if (!i_stall && !i_halt_seen) begin
            pc_q <= pc_q + 32'd1;
        end
    end

    // IF/ID, all-zero word decodes as a NOP
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ifid_instr <= '0;
            o_ifid_pc    <= '0;
        end else if (i_flush || i_halt_seen) begin
            o_ifid_instr <= '0;
        end else if (!i_stall) begin
            o_ifid_instr <= fetch_instr;
            o_ifid_pc    <= pc_q;
        end
    end

endmodule

//--- source/register_file.sv
module register_file (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  mips_pkg::reg_idx_t    i_rs,
    input  mips_pkg::reg_idx_t    i_rt,
    input  mips_pkg::reg_idx_t    i_dbg_addr,
    mem_wb_link.consumer          i_mem_wb,
    output mips_pkg::word_t       o_rs_data,
    output mips_pkg::word_t       o_rt_data,
    output mips_pkg::word_t       o_dbg_data
);

    mips_pkg::word_t regs [mips_pkg::NUM_REGS];
    logic            wr_en;

    // r0 is never written
    assign wr_en = i_mem_wb.reg_write && (i_mem_wb.dest != '0);

    // Same-cycle writeback value wins
    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_idx_t idx);
        if (wr_en && (i_mem_wb.dest == idx)) begin
            return i_mem_wb.wb_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_mem_wb.dest] <= i_mem_wb.wb_data;
        end
    end

    assign o_rs_data  = read_port(i_rs);
    assign o_rt_data  = read_port(i_rt);
    assign o_dbg_data = regs[i_dbg_addr];

endmodule

//--- source/stage_decode.sv
module stage_decode (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  mips_pkg::word_t       i_instr,
    input  mips_pkg::word_t       i_pc,
    input  mips_pkg::word_t       i_rs_data,
    input  mips_pkg::word_t       i_rt_data,
    input  logic                  i_stall,
    input  logic                  i_flush,
    output mips_pkg::reg_idx_t    o_rs,
    output mips_pkg::reg_idx_t    o_rt,
    output logic                  o_halt_seen,
    id_ex_link.producer           o_id_ex
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    mips_pkg::reg_idx_t rd;
    mips_pkg::alu_op_t  alu_op;
    logic               alu_src_imm;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               branch_eq;
    logic               branch_ne;
    logic               is_halt;
    logic               dest_rd;
    logic               bubble;
    logic               halt_q;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];
    assign o_rs   = i_instr[25:21];
    assign o_rt   = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign bubble = i_stall || i_flush;

    always_comb begin
        alu_op      = mips_pkg::ALU_ADD;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch_eq   = 1'b0;
        branch_ne   = 1'b0;
        is_halt     = 1'b0;
        dest_rd     = 1'b0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                dest_rd   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    // Unsupported funct, incl. the all-zero NOP
                    default:           reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDI: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            mips_pkg::OP_LW: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                mem_read    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            mips_pkg::OP_BEQ:  branch_eq = 1'b1;
            mips_pkg::OP_BNE:  branch_ne = 1'b1;
            mips_pkg::OP_HALT: is_halt   = 1'b1;
            default: ;
        endcase
    end

    // Sticky once a HALT survives decode
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halt_q <= 1'b0;
        end else if (is_halt && !i_flush) begin
            halt_q <= 1'b1;
        end
    end

    assign o_halt_seen = halt_q || (is_halt && !i_flush);

    // ID/EX control
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex.alu_op      <= mips_pkg::ALU_ADD;
            o_id_ex.alu_src_imm <= 1'b0;
            o_id_ex.reg_write   <= 1'b0;
            o_id_ex.mem_read    <= 1'b0;
            o_id_ex.mem_write   <= 1'b0;
            o_id_ex.branch_eq   <= 1'b0;
            o_id_ex.branch_ne   <= 1'b0;
            o_id_ex.halt        <= 1'b0;
        end else begin
            o_id_ex.alu_op      <= bubble ? mips_pkg::ALU_ADD : alu_op;
            o_id_ex.alu_src_imm <= alu_src_imm && !bubble;
            o_id_ex.reg_write   <= reg_write && !bubble;
            o_id_ex.mem_read    <= mem_read && !bubble;
            o_id_ex.mem_write   <= mem_write && !bubble;
            o_id_ex.branch_eq   <= branch_eq && !bubble;
            o_id_ex.branch_ne   <= branch_ne && !bubble;
            o_id_ex.halt        <= is_halt && !bubble;
        end
    end

    // ID/EX payload
    always_ff @(posedge i_clk) begin
        o_id_ex.rs_data <= i_rs_data;
        o_id_ex.rt_data <= i_rt_data;
        o_id_ex.rs      <= o_rs;
        o_id_ex.rt      <= o_rt;
        o_id_ex.dest    <= dest_rd ? rd : o_rt;
        o_id_ex.imm     <= {{16{i_instr[15]}}, i_instr[15:0]};
        o_id_ex.pc      <= i_pc;
    end

endmodule

//--- source/hazard_unit.sv
module hazard_unit (
    input  mips_pkg::reg_idx_t    i_ifid_rs,
    input  mips_pkg::reg_idx_t    i_ifid_rt,
    input  logic                  i_branch_taken,
    id_ex_link.watch              i_id_ex,
    ex_mem_link.watch             i_ex_mem,
    mem_wb_link.watch             i_mem_wb,
    output logic                  o_stall,
    output logic                  o_flush,
    output mips_pkg::fwd_sel_t    o_fwd_a,
    output mips_pkg::fwd_sel_t    o_fwd_b
);

    // Nearest older writer first
    function automatic mips_pkg::fwd_sel_t fwd_for(input mips_pkg::reg_idx_t src);
        if (src == '0) begin
            return mips_pkg::FWD_NONE;
        end
        if (i_ex_mem.reg_write && (i_ex_mem.dest == src)) begin
            return mips_pkg::FWD_EXMEM;
        end
        if (i_mem_wb.reg_write && (i_mem_wb.dest == src)) begin
            return mips_pkg::FWD_MEMWB;
        end
        return mips_pkg::FWD_NONE;
    endfunction

    assign o_fwd_a = fwd_for(i_id_ex.rs);
    assign o_fwd_b = fwd_for(i_id_ex.rt);

    // Load result not ready for the instruction right behind it
    assign o_stall = i_id_ex.mem_read && (i_id_ex.dest != '0) &&
                     ((i_id_ex.dest == i_ifid_rs) || (i_id_ex.dest == i_ifid_rt));

    assign o_flush = i_branch_taken;

endmodule

//--- source/stage_execute.sv
module stage_execute (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  mips_pkg::fwd_sel_t    i_fwd_a,
    input  mips_pkg::fwd_sel_t    i_fwd_b,
    id_ex_link.consumer           i_id_ex,
    mem_wb_link.watch             i_mem_wb,
    ex_mem_link.producer          o_ex_mem,
    output logic                  o_branch_taken,
    output mips_pkg::word_t       o_branch_target
);

    mips_pkg::word_t op_a;
    mips_pkg::word_t op_b_reg;
    mips_pkg::word_t op_b;
    mips_pkg::word_t alu_result;

    function automatic mips_pkg::word_t pick(input mips_pkg::fwd_sel_t sel,
                                             input mips_pkg::word_t reg_val,
                                             input mips_pkg::word_t exmem_val,
                                             input mips_pkg::word_t memwb_val);
        case (sel)
            mips_pkg::FWD_EXMEM: return exmem_val;
            mips_pkg::FWD_MEMWB: return memwb_val;
            default:             return reg_val;
        endcase
    endfunction

    assign op_a     = pick(i_fwd_a, i_id_ex.rs_data, o_ex_mem.alu_result, i_mem_wb.wb_data);
    assign op_b_reg = pick(i_fwd_b, i_id_ex.rt_data, o_ex_mem.alu_result, i_mem_wb.wb_data);
    assign op_b     = i_id_ex.alu_src_imm ? i_id_ex.imm : op_b_reg;

    always_comb begin
        case (i_id_ex.alu_op)
            mips_pkg::ALU_SUB: alu_result = op_a - op_b;
            mips_pkg::ALU_AND: alu_result = op_a & op_b;
            mips_pkg::ALU_OR:  alu_result = op_a | op_b;
            mips_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:           alu_result = op_a + op_b;
        endcase
    end

    // Branch resolves here, target in words
    assign o_branch_taken  = (i_id_ex.branch_eq && (op_a == op_b_reg)) ||
                             (i_id_ex.branch_ne && (op_a != op_b_reg));
    assign o_branch_target = i_id_ex.pc + 32'd1 + i_id_ex.imm;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem.reg_write <= 1'b0;
            o_ex_mem.mem_read  <= 1'b0;
            o_ex_mem.mem_write <= 1'b0;
            o_ex_mem.halt      <= 1'b0;
        end else begin
            o_ex_mem.reg_write <= i_id_ex.reg_write;
            o_ex_mem.mem_read  <= i_id_ex.mem_read;
            o_ex_mem.mem_write <= i_id_ex.mem_write;
            o_ex_mem.halt      <= i_id_ex.halt;
        end
    end

    always_ff @(posedge i_clk) begin
        o_ex_mem.alu_result <= alu_result;
        o_ex_mem.store_data <= op_b_reg;
        o_ex_mem.dest       <= i_id_ex.dest;
    end

endmodule

//--- source/stage_memory.sv
module stage_memory (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  mips_pkg::dmem_addr_t  i_dbg_addr,
    ex_mem_link.consumer          i_ex_mem,
    mem_wb_link.producer          o_mem_wb,
    output mips_pkg::word_t       o_dbg_data
);

    mips_pkg::word_t      dmem [mips_pkg::DMEM_DEPTH];
    mips_pkg::dmem_addr_t addr;
    mips_pkg::word_t      wb_sel;

    // Word address from the low ALU bits
    assign addr = mips_pkg::dmem_addr_t'(i_ex_mem.alu_result);

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.mem_write) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    assign wb_sel     = i_ex_mem.mem_read ? dmem[addr] : i_ex_mem.alu_result;
    assign o_dbg_data = dmem[i_dbg_addr];

    // halt stays set until reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_wb.reg_write <= 1'b0;
            o_mem_wb.halt      <= 1'b0;
        end else begin
            o_mem_wb.reg_write <= i_ex_mem.reg_write;
            o_mem_wb.halt      <= o_mem_wb.halt || i_ex_mem.halt;
        end
    end

    always_ff @(posedge i_clk) begin
        o_mem_wb.wb_data <= wb_sel;
        o_mem_wb.dest    <= i_ex_mem.dest;
    end

endmodule

//--- source/mips_top.sv
module mips_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_imem_we,
    input  mips_pkg::imem_addr_t  i_imem_addr,
    input  mips_pkg::word_t       i_imem_data,
    input  mips_pkg::reg_idx_t    i_dbg_reg_addr,
    input  mips_pkg::dmem_addr_t  i_dbg_mem_addr,
    output mips_pkg::word_t       o_pc,
    output mips_pkg::word_t       o_dbg_reg_data,
    output mips_pkg::word_t       o_dbg_mem_data,
    output logic                  o_halt
);

    mips_pkg::word_t    ifid_instr;
    mips_pkg::word_t    ifid_pc;
    mips_pkg::reg_idx_t rs;
    mips_pkg::reg_idx_t rt;
    mips_pkg::word_t    rs_data;
    mips_pkg::word_t    rt_data;
    mips_pkg::fwd_sel_t fwd_a;
    mips_pkg::fwd_sel_t fwd_b;
    mips_pkg::word_t    branch_target;
    logic               branch_taken;
    logic               stall;
    logic               flush;
    logic               halt_seen;

    id_ex_link  id_ex ();
    ex_mem_link ex_mem ();
    mem_wb_link mem_wb ();

    assign o_halt = mem_wb.halt;

    stage_fetch u_fetch (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .i_stall         (stall),
        .i_flush         (flush),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .i_halt_seen     (halt_seen),
        .o_pc            (o_pc),
        .o_ifid_instr    (ifid_instr),
        .o_ifid_pc       (ifid_pc)
    );

    stage_decode u_decode (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_instr     (ifid_instr),
        .i_pc        (ifid_pc),
        .i_rs_data   (rs_data),
        .i_rt_data   (rt_data),
        .i_stall     (stall),
        .i_flush     (flush),
        .o_rs        (rs),
        .o_rt        (rt),
        .o_halt_seen (halt_seen),
        .o_id_ex     (id_ex.producer)
    );

    register_file u_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs       (rs),
        .i_rt       (rt),
        .i_dbg_addr (i_dbg_reg_addr),
        .i_mem_wb   (mem_wb.consumer),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_reg_data)
    );

    hazard_unit u_hazard (
        .i_ifid_rs      (rs),
        .i_ifid_rt      (rt),
        .i_branch_taken (branch_taken),
        .i_id_ex        (id_ex.watch),
        .i_ex_mem       (ex_mem.watch),
        .i_mem_wb       (mem_wb.watch),
        .o_stall        (stall),
        .o_flush        (flush),
        .o_fwd_a        (fwd_a),
        .o_fwd_b        (fwd_b)
    );

    stage_execute u_execute (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_fwd_a         (fwd_a),
        .i_fwd_b         (fwd_b),
        .i_id_ex         (id_ex.consumer),
        .i_mem_wb        (mem_wb.watch),
        .o_ex_mem        (ex_mem.producer),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target)
    );

    stage_memory u_memory (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_dbg_addr (i_dbg_mem_addr),
        .i_ex_mem   (ex_mem.consumer),
        .o_mem_wb   (mem_wb.producer),
        .o_dbg_data (o_dbg_mem_data)
    );

endmodule

//--- verif/tb_mips.sv
module tb_mips;

    logic                 clk;
    logic                 rst_n;
    logic                 imem_we;
    mips_pkg::imem_addr_t imem_addr;
    mips_pkg::word_t      imem_data;
    mips_pkg::reg_idx_t   dbg_reg_addr;
    mips_pkg::dmem_addr_t dbg_mem_addr;
    mips_pkg::word_t      pc;
    mips_pkg::word_t      dbg_reg_data;
    mips_pkg::word_t      dbg_mem_data;
    logic                 halt;

    // One trace entry per data line
    byte                  trace_tag[$];
    int unsigned          trace_addr[$];
    mips_pkg::word_t      trace_val[$];

    int                   cycles;
    int                   prog_len;
    int                   cycle_limit;
    mips_pkg::word_t      halt_pc;
    mips_pkg::word_t      expected_halt_pc;

    mips_top dut0 (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_imem_we      (imem_we),
        .i_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .i_dbg_reg_addr (dbg_reg_addr),
        .i_dbg_mem_addr (dbg_mem_addr),
        .o_pc           (pc),
        .o_dbg_reg_data (dbg_reg_data),
        .o_dbg_mem_data (dbg_mem_data),
        .o_halt         (halt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_failure;
        $display("Test failures found");
        $fatal(1, "Run stopped on the first failure");
    endtask

    task automatic check_value(input string name, input mips_pkg::word_t expected,
                               input mips_pkg::word_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Skip lines starting with #
    // Data lines hold tag, address and value
    task automatic read_trace;
        int              fd;
        int              n;
        string           line;
        byte             tag;
        int unsigned     addr;
        mips_pkg::word_t value;
        fd = $fopen("verif/program_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file verif/program_trace.txt");
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h", tag, addr, value);
                if (n == 3) begin
                    trace_tag.push_back(tag);
                    trace_addr.push_back(addr);
                    trace_val.push_back(value);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rst_n        = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        dbg_reg_addr = '0;
        dbg_mem_addr = '0;
        cycles       = 0;
        prog_len     = 0;

        read_trace();

        // Load program while the core sits in reset
        for (int i = 0; i < trace_tag.size(); i++) begin
            if (trace_tag[i] == "I") begin
                @(posedge clk);
                imem_we   <= 1'b1;
                imem_addr <= mips_pkg::imem_addr_t'(trace_addr[i]);
                imem_data <= trace_val[i];
                prog_len++;
                expected_halt_pc = trace_addr[i] + 1;
            end
        end
        @(posedge clk);
        imem_we <= 1'b0;
        if (prog_len == 0) begin
            $display("The trace file holds no program words");
            stop_on_failure();
        end
        cycle_limit = 4 * prog_len + 40;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        while (halt !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("Halt never reached within %0d cycles", cycle_limit);
                stop_on_failure();
            end
        end

        // Fetch freezes one word past HALT
        halt_pc = pc;
        check_value("halt pc", expected_halt_pc, halt_pc);
        repeat (8) begin
            @(negedge clk);
            check_value("pc hold", halt_pc, pc);
            check_value("halt hold", 32'd1, {31'd0, halt});
        end

        for (int i = 0; i < trace_tag.size(); i++) begin
            if (trace_tag[i] == "R") begin
                @(posedge clk);
                dbg_reg_addr <= mips_pkg::reg_idx_t'(trace_addr[i]);
                @(negedge clk);
                check_value($sformatf("reg r%0d", trace_addr[i]), trace_val[i], dbg_reg_data);
            end else if (trace_tag[i] == "M") begin
                @(posedge clk);
                dbg_mem_addr <= mips_pkg::dmem_addr_t'(trace_addr[i]);
                @(negedge clk);
                check_value($sformatf("mem[%0d]", trace_addr[i]), trace_val[i], dbg_mem_data);
            end else if (trace_tag[i] != "I") begin
                $display("Unknown tag in trace line %0d", i);
                stop_on_failure();
            end
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verif/program_trace.txt
# I <imem addr> <instruction>, R <reg> <expected>, M <dmem addr> <expected>
# all numbers hex
I 00 20010005
I 01 20220003
I 02 00221821
I 03 00612023
I 04 00622824
I 05 00623025
I 06 0022382A
I 07 2008FFFC
I 08 0101482A
I 09 AC030002
I 0A 8C0A0002
I 0B 01415821
I 0C 20000007
I 0D 00017821
I 0E 10820002
I 0F 200C0001
I 10 200D0001
I 11 14820001
I 12 200E0009
I 13 AC0E0003
I 14 FC000000
R 00 00000000
R 01 00000005
R 02 00000008
R 03 0000000D
R 04 00000008
R 05 00000008
R 06 0000000D
R 07 00000001
R 08 FFFFFFFC
R 09 00000001
R 0A 0000000D
R 0B 00000012
R 0C 00000000
R 0D 00000000
R 0E 00000009
R 0F 00000005
M 02 0000000D
M 03 00000009

//--- tb.f
source/mips_pkg.sv
source/pipe_links.sv
source/stage_fetch.sv
source/register_file.sv
source/stage_decode.sv
source/hazard_unit.sv
source/stage_execute.sv
source/stage_memory.sv
source/mips_top.sv
verif/tb_mips.sv
